/* hdl/input_queue.sv */
/*
  Input queue of one router port
  Four-flit circular buffer, bypassed while empty
  Stop generation towards the upstream sender
  Saved routing field so a whole worm requests one output
*/

`timescale 1ns/1ns

module input_queue (
  input  logic           clk,
  input  logic           rst,
  input  noc_pkg::flit_t data_i,
  input  logic           void_i,
  input  logic           rd_i,
  output noc_pkg::flit_t head_o,
  output logic           empty_o,
  output noc_pkg::dir_t  req_dir_o,
  output logic           stop_o
);

  import noc_pkg::*;

  flit_t   mem [queue_depth];
  qptr_t   wr_ptr;
  qptr_t   rd_ptr;
  qcount_t count;
  qcount_t count_next;
  logic    stop_q;
  logic    buf_empty;
  logic    head_valid;
  logic    rd_en;
  logic    mem_rd;
  logic    wr_en;
  dir_t    saved_dir;

  // Empty buffer shows the link word directly at the head
  assign buf_empty  = (count == '0);
  assign head_o     = buf_empty ? data_i : mem[rd_ptr];
  assign empty_o    = buf_empty & void_i;
  assign head_valid = ~empty_o;

  // Read only a valid flit
  assign rd_en  = rd_i & head_valid;
  assign mem_rd = rd_en & ~buf_empty;

  // Write unless stopped or the flit passes straight through
  assign wr_en = ~void_i & ~stop_q & ~(buf_empty & rd_en);

  always_comb begin
    count_next = count;
    if (wr_en && !mem_rd) begin
      count_next = count + 1'b1;
    end else if (!wr_en && mem_rd) begin
      count_next = count - 1'b1;
    end
  end

  // Pointers wrap on the power-of-two depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      stop_q <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count  <= count_next;
      // Full flag, registered
      stop_q <= (count_next == qcount_t'(queue_depth));
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= data_i;
    end
  end

  assign stop_o = stop_q;

  // Worm direction held from the head until the tail is read
  always_ff @(posedge clk) begin
    if (rst) begin
      saved_dir <= '0;
    end else if (rd_en && head_o[tail_bit]) begin
      saved_dir <= '0;
    end else if (head_valid && head_o[head_bit]) begin
      saved_dir <= head_o[$bits(dir_t)-1:0];
    end
  end

  assign req_dir_o = (head_valid && head_o[head_bit]) ? head_o[$bits(dir_t)-1:0] : saved_dir;

  // Stop register must agree with the occupancy
  a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> (count < qcount_t'(queue_depth)))
    else $error("input_queue: write accepted while full");

endmodule

/* hdl/lookahead_route.sv */
/*
  Look-ahead XY route for one output
  Direction the flit takes at the neighboring router
*/

`timescale 1ns/1ns

module lookahead_route (
  input  noc_pkg::xy_t       position_i,
  input  noc_pkg::port_idx_t out_dir_i,
  input  noc_pkg::xy_t       dest_i,
  output noc_pkg::dir_t      next_dir_o
);

  import noc_pkg::*;

  coord_t cur_x;
  coord_t cur_y;
  coord_t dst_x;
  coord_t dst_y;
  coord_t nbr_x;
  coord_t nbr_y;

  assign cur_x = position_i[2*coord_width-1:coord_width];
  assign cur_y = position_i[coord_width-1:0];
  assign dst_x = dest_i[2*coord_width-1:coord_width];
  assign dst_y = dest_i[coord_width-1:0];

  // Neighbor tile behind this output, north is y minus 1
  always_comb begin
    nbr_x = cur_x;
    nbr_y = cur_y;
    case (out_dir_i)
      north_port: nbr_y = cur_y - 1'b1;
      south_port: nbr_y = cur_y + 1'b1;
      west_port:  nbr_x = cur_x - 1'b1;
      east_port:  nbr_x = cur_x + 1'b1;
      default: ;
    endcase
  end

  // X first, then Y
  always_comb begin
    if (out_dir_i == local_port) begin
      next_dir_o = go_local;
    end else if (dst_x > nbr_x) begin
      next_dir_o = go_east;
    end else if (dst_x < nbr_x) begin
      next_dir_o = go_west;
    end else if (dst_y > nbr_y) begin
      next_dir_o = go_south;
    end else if (dst_y < nbr_y) begin
      next_dir_o = go_north;
    end else begin
      next_dir_o = go_local;
    end
  end

endmodule

/* hdl/mesh_router.sv */
/*
  Five-port mesh router, XY look-ahead routing, wormhole switching
  Input queues, per-output arbiters and output paths
  Request transpose and queue read merge
*/

`timescale 1ns/1ns

module mesh_router (
  input  logic                          clk,
  input  logic                          rst,
  input  noc_pkg::xy_t                  position_i,
  input  noc_pkg::flit_t                data_n_i,
  input  noc_pkg::flit_t                data_s_i,
  input  noc_pkg::flit_t                data_w_i,
  input  noc_pkg::flit_t                data_e_i,
  input  noc_pkg::flit_t                data_p_i,
  input  logic [noc_pkg::num_ports-1:0] void_i,
  output logic [noc_pkg::num_ports-1:0] stop_o,
  output noc_pkg::flit_t                data_n_o,
  output noc_pkg::flit_t                data_s_o,
  output noc_pkg::flit_t                data_w_o,
  output noc_pkg::flit_t                data_e_o,
  output noc_pkg::flit_t                data_p_o,
  output logic [noc_pkg::num_ports-1:0] void_o,
  input  logic [noc_pkg::num_ports-1:0] stop_i
);

  import noc_pkg::*;

  flit_t [num_ports-1:0]                in_data;
  flit_t [num_ports-1:0]                q_head;
  logic  [num_ports-1:0]                q_empty;
  dir_t  [num_ports-1:0]                q_req;
  logic  [num_ports-1:0]                rd_or;
  flit_t [num_ports-1:0]                out_data;
  logic  [num_ports-1:0][num_ports-1:0] out_req;
  logic  [num_ports-1:0][num_ports-1:0] out_grant;
  logic  [num_ports-1:0][num_ports-1:0] out_rd;
  logic  [num_ports-1:0]                forwarding;
  logic  [num_ports-1:0]                fwd_head;
  logic  [num_ports-1:0]                fwd_tail;

  assign in_data[north_port] = data_n_i;
  assign in_data[south_port] = data_s_i;
  assign in_data[west_port]  = data_w_i;
  assign in_data[east_port]  = data_e_i;
  assign in_data[local_port] = data_p_i;

  assign data_n_o = out_data[north_port];
  assign data_s_o = out_data[south_port];
  assign data_w_o = out_data[west_port];
  assign data_e_o = out_data[east_port];
  assign data_p_o = out_data[local_port];

  ////////////////////////////////////////////////////////////
  // Input stage
  ////////////////////////////////////////////////////////////

  for (genvar g_i = 0; g_i < num_ports; g_i++) begin : gen_input
    input_queue input_queue_inst (
      .clk       (clk),
      .rst       (rst),
      .data_i    (in_data[g_i]),
      .void_i    (void_i[g_i]),
      .rd_i      (rd_or[g_i]),
      .head_o    (q_head[g_i]),
      .empty_o   (q_empty[g_i]),
      .req_dir_o (q_req[g_i]),
      .stop_o    (stop_o[g_i])
    );
  end

  ////////////////////////////////////////////////////////////
  // Arbitration and output stage
  ////////////////////////////////////////////////////////////

  for (genvar g_o = 0; g_o < num_ports; g_o++) begin : gen_output
    // No U-turn: an input never requests its own output
    for (genvar g_i = 0; g_i < num_ports; g_i++) begin : gen_transpose
      if (g_i == g_o) begin : gen_self
        assign out_req[g_o][g_i] = 1'b0;
      end else begin : gen_other
        assign out_req[g_o][g_i] = q_req[g_i][g_o];
      end
    end

    output_arbiter output_arbiter_inst (
      .clk          (clk),
      .rst          (rst),
      .req_i        (out_req[g_o]),
      .fwd_head_i   (fwd_head[g_o]),
      .fwd_tail_i   (fwd_tail[g_o]),
      .stall_i      (stop_i[g_o]),
      .grant_o      (out_grant[g_o]),
      .forwarding_o (forwarding[g_o])
    );

    output_port output_port_inst (
      .clk          (clk),
      .rst          (rst),
      .position_i   (position_i),
      .out_idx_i    (port_idx_t'(g_o)),
      .heads_i      (q_head),
      .empty_i      (q_empty),
      .grant_i      (out_grant[g_o]),
      .forwarding_i (forwarding[g_o]),
      .stop_i       (stop_i[g_o]),
      .data_o       (out_data[g_o]),
      .void_o       (void_o[g_o]),
      .rd_o         (out_rd[g_o]),
      .fwd_head_o   (fwd_head[g_o]),
      .fwd_tail_o   (fwd_tail[g_o])
    );
  end

  // Each queue is read by whichever output holds it
  always_comb begin : read_merge
    rd_or = '0;
    for (int o = 0; o < num_ports; o++) begin
      rd_or = rd_or | out_rd[o];
    end
  end

endmodule

/* hdl/noc_pkg.sv */
/*
  Shared definitions for the five-port mesh router
  Link word, coordinate and direction types
  Port index and one-hot direction constants
  Queue depth and head flit field positions
  Worm lock FSM states
*/

package noc_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int num_ports   = 5;
  localparam int queue_depth = 4;
  localparam int data_width  = 32;
  // Two preamble bits on top of the data
  localparam int flit_width  = data_width + 2;
  localparam int coord_width = 3;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // One mesh coordinate
  typedef logic [coord_width-1:0] coord_t;

  // Tile position, x in the upper half and y in the lower half
  typedef logic [2*coord_width-1:0] xy_t;

  // One-hot output direction, bit 0 north up to bit 4 local
  typedef logic [num_ports-1:0] dir_t;

  // Port number 0 to 4
  typedef logic [2:0] port_idx_t;

  // Link word: head bit, tail bit, then data
  typedef logic [flit_width-1:0] flit_t;

  // Queue pointer and occupancy
  typedef logic [$clog2(queue_depth)-1:0] qptr_t;
  typedef logic [$clog2(queue_depth):0]   qcount_t;

  // Worm lock FSM of each output
  typedef enum logic {
    head_flit     = 1'b0,
    payload_flits = 1'b1
  } worm_state_t;

  // Preamble bit positions
  localparam int head_bit = flit_width - 1;
  localparam int tail_bit = flit_width - 2;

  // Head flit data from the top: destination, source, 15 reserved bits,
  // routing field in the lowest bits
  localparam int dest_lsb = data_width - $bits(xy_t);

  ////////////////////////////////////////////////////////////
  // Port indices and directions
  ////////////////////////////////////////////////////////////

  localparam port_idx_t north_port = 3'd0;
  localparam port_idx_t south_port = 3'd1;
  localparam port_idx_t west_port  = 3'd2;
  localparam port_idx_t east_port  = 3'd3;
  localparam port_idx_t local_port = 3'd4;

  localparam dir_t go_north = 5'b00001;
  localparam dir_t go_south = 5'b00010;
  localparam dir_t go_west  = 5'b00100;
  localparam dir_t go_east  = 5'b01000;
  localparam dir_t go_local = 5'b10000;

endpackage

/* hdl/output_arbiter.sv */
/*
  Round-robin arbiter of one router output
  Worm lock FSM holds the grant from head to tail
*/

`timescale 1ns/1ns

module output_arbiter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [noc_pkg::num_ports-1:0] req_i,
  input  logic                          fwd_head_i,
  input  logic                          fwd_tail_i,
  input  logic                          stall_i,
  output logic [noc_pkg::num_ports-1:0] grant_o,
  output logic                          forwarding_o
);

  import noc_pkg::*;

  worm_state_t          state;
  port_idx_t            prio;
  port_idx_t            next_prio;
  logic [num_ports-1:0] rr_grant;
  logic [num_ports-1:0] saved_grant;

  // First requester at or after the priority pointer
  always_comb begin : rr_pick
    int unsigned idx;
    rr_grant = '0;
    for (int k = 0; k < num_ports; k++) begin
      idx = prio + k;
      if (idx >= num_ports) begin
        idx = idx - num_ports;
      end
      if (req_i[idx] && rr_grant == '0) begin
        rr_grant[idx] = 1'b1;
      end
    end
  end

  // Locked worm keeps its input, a new head waits for a free link
  assign grant_o = (state == payload_flits) ? saved_grant :
                   (stall_i ? '0 : rr_grant);
  assign forwarding_o = (state == payload_flits) | (|grant_o);

  // Input after the winner
  always_comb begin : winner_next
    next_prio = prio;
    for (int k = 0; k < num_ports; k++) begin
      if (grant_o[k]) begin
        next_prio = (k == num_ports - 1) ? '0 : port_idx_t'(k + 1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Worm lock FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= head_flit;
      prio        <= '0;
      saved_grant <= '0;
    end else begin
      // Priority moves once per worm
      if (fwd_tail_i) begin
        prio <= next_prio;
      end
      case (state)
        head_flit: begin
          if (fwd_head_i && !fwd_tail_i) begin
            state       <= payload_flits;
            saved_grant <= grant_o;
          end
        end
        payload_flits: begin
          if (fwd_tail_i) begin
            state <= head_flit;
          end
        end
        default: state <= head_flit;
      endcase
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant_o))
    else $error("output_arbiter: grant is not one-hot");

endmodule

/* hdl/output_port.sv */
/*
  Output path of one router port
  Crossbar select of the granted queue head
  Look-ahead routing field written into head flits
  Output register, void bit and queue read strobe
*/

`timescale 1ns/1ns

module output_port (
  input  logic                                    clk,
  input  logic                                    rst,
  input  noc_pkg::xy_t                            position_i,
  input  noc_pkg::port_idx_t                      out_idx_i,
  input  noc_pkg::flit_t [noc_pkg::num_ports-1:0] heads_i,
  input  logic [noc_pkg::num_ports-1:0]           empty_i,
  input  logic [noc_pkg::num_ports-1:0]           grant_i,
  input  logic                                    forwarding_i,
  input  logic                                    stop_i,
  output noc_pkg::flit_t                          data_o,
  output logic                                    void_o,
  output logic [noc_pkg::num_ports-1:0]           rd_o,
  output logic                                    fwd_head_o,
  output logic                                    fwd_tail_o
);

  import noc_pkg::*;

  flit_t sel_flit;
  logic  sel_valid;
  xy_t   sel_dest;
  dir_t  next_dir;
  flit_t out_flit;
  logic  insert_q;
  logic  move;

  // Crossbar column for this output
  always_comb begin : crossbar
    sel_flit  = '0;
    sel_valid = 1'b0;
    for (int j = 0; j < num_ports; j++) begin
      if (grant_i[j]) begin
        sel_flit  = heads_i[j];
        sel_valid = ~empty_i[j];
      end
    end
  end

  assign sel_dest = sel_flit[dest_lsb +: $bits(xy_t)];

  lookahead_route lookahead_route_inst (
    .position_i (position_i),
    .out_dir_i  (out_idx_i),
    .dest_i     (sel_dest),
    .next_dir_o (next_dir)
  );

  // Routing field replaced only on the first flit of a worm
  assign out_flit = insert_q ? {sel_flit[flit_width-1:$bits(dir_t)], next_dir} : sel_flit;

  // A flit moves when granted, present, and the link is free
  assign move       = forwarding_i & sel_valid & ~stop_i;
  assign rd_o       = grant_i & {num_ports{move}};
  assign fwd_head_o = move & out_flit[head_bit];
  assign fwd_tail_o = move & out_flit[tail_bit];

  // Next flit is a head after reset and after each tail
  always_ff @(posedge clk) begin
    if (rst) begin
      insert_q <= 1'b1;
    end else if (fwd_tail_o) begin
      insert_q <= 1'b1;
    end else if (fwd_head_o) begin
      insert_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (move) begin
      data_o <= out_flit;
    end
  end

  // Void and data hold while the receiver stops
  always_ff @(posedge clk) begin
    if (rst) begin
      void_o <= 1'b1;
    end else if (!stop_i) begin
      void_o <= ~move;
    end
  end

  // Arbiter idle means this output expects a new worm
  a_idle_selects_head: assert property (@(posedge clk) disable iff (rst)
    insert_q && forwarding_i && sel_valid |-> sel_flit[head_bit])
    else $error("output_port: payload flit selected while arbiter idle");

endmodule

/* list.f */
hdl/noc_pkg.sv
hdl/input_queue.sv
hdl/output_arbiter.sv
hdl/lookahead_route.sv
hdl/output_port.sv
hdl/mesh_router.sv
testbench/tb_router_model.sv
testbench/tb_mesh_router.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mesh router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mesh_router -f list.f -o sim_router

# The log decides the result, so a failing run must not stop the script here
./obj_dir/sim_router > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
if ! grep -q "sim passed" sim.log; then
  exit 1
fi
exit 0

/* testbench/tb_mesh_router.sv */
/*
  Testbench of the five-port mesh router at tile (2,2)
  LFSR worms on all inputs and random stop on all outputs
  Directed checks of reset, latency and back-pressure
  Deliveries checked against the reference model
*/

`timescale 1ns/1ns

module tb_mesh_router;

  import noc_pkg::*;

  logic           clk = 1'b0;
  logic           rst;
  xy_t            position;
  flit_t          in_data [num_ports];
  flit_t          out_data [num_ports];
  logic [4:0]     void_i;
  logic [4:0]     stop_o;
  logic [4:0]     void_o;
  logic [4:0]     stop_i;

  // Stimulus store per input
  flit_t          inj_flit [num_ports][1024];
  int             inj_cnt [num_ports];
  int             inj_idx [num_ports];
  int             acc_cnt [num_ports];
  int             seq [num_ports];
  bit             gaps_on;
  int             stop_mode;
  logic [4:0]     stop_force;
  logic [31:0]    lfsr = 32'h36bb;

  // Output snapshot for the hold check
  flit_t          prev_data [num_ports];
  logic [4:0]     prev_void;
  logic [4:0]     hold_prev;

  always #4 clk = ~clk;

  mesh_router mesh_router_inst (
    .clk        (clk),
    .rst        (rst),
    .position_i (position),
    .data_n_i   (in_data[0]),
    .data_s_i   (in_data[1]),
    .data_w_i   (in_data[2]),
    .data_e_i   (in_data[3]),
    .data_p_i   (in_data[4]),
    .void_i     (void_i),
    .stop_o     (stop_o),
    .data_n_o   (out_data[0]),
    .data_s_o   (out_data[1]),
    .data_w_o   (out_data[2]),
    .data_e_o   (out_data[3]),
    .data_p_o   (out_data[4]),
    .void_o     (void_o),
    .stop_i     (stop_i)
  );

  tb_router_model model_inst (
    .position_i (position)
  );

  ////////////////////////////////////////////////////////////
  // Random numbers and checks
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "testbench stopped");
  endtask

  task automatic check_flit(string name, flit_t got, flit_t exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      stop_on_error("Flit mismatch");
    end
  endtask

  task automatic check_dir(string name, dir_t got, dir_t exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      stop_on_error("Routing field mismatch");
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      stop_on_error("Bit mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Worm generation
  ////////////////////////////////////////////////////////////

  // Head carries dest, source tag, sequence and this tile's direction
  task automatic push_worm(int i, xy_t dest, int len);
    flit_t f;
    dir_t  d;
    d = '0;
    d[model_inst.xy_port(position, dest)] = 1'b1;
    for (int k = 0; k < len; k++) begin
      if (k == 0) begin
        f = {1'b1, len == 1, dest, xy_t'(i), 15'(seq[i]), d};
      end else begin
        f = {1'b0, k == len - 1, 3'(i), 29'(seq[i])};
      end
      inj_flit[i][inj_cnt[i]] = f;
      inj_cnt[i]++;
      seq[i]++;
    end
  endtask

  // Destinations never turn back through the input they came from
  task automatic random_worm(int i);
    coord_t dx;
    coord_t dy;
    int     len;
    dx = coord_t'(rand_bits(3));
    dy = coord_t'(rand_bits(3));
    case (i)
      0: begin
        dx = 3'd2;
        dy = coord_t'(2 + int'(dy) % 6);
      end
      1: begin
        dx = 3'd2;
        dy = coord_t'(int'(dy) % 3);
      end
      2: dx = coord_t'(2 + int'(dx) % 6);
      3: dx = coord_t'(int'(dx) % 3);
      default: if (dx == 3'd2 && dy == 3'd2) dx = 3'd3;
    endcase
    len = 1 + int'(rand_bits(2));
    push_worm(i, {dx, dy}, len);
  endtask

  function automatic bit all_drained();
    for (int i = 0; i < num_ports; i++) begin
      if (inj_idx[i] != inj_cnt[i]) return 1'b0;
    end
    return (void_i == 5'h1f) && (void_o == 5'h1f) && (model_inst.pending() == 0);
  endfunction

  task automatic wait_drained(int limit, string what);
    int n;
    n = 0;
    while (!all_drained() && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!all_drained()) stop_on_error({"Timeout while draining ", what});
  endtask

  ////////////////////////////////////////////////////////////
  // Input and stop drivers
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : drive_inputs
    logic acc;
    if (rst) begin
      void_i <= '1;
      stop_i <= '0;
    end else begin
      for (int i = 0; i < num_ports; i++) begin
        // Transfer when void and stop are both low
        acc = !void_i[i] && !stop_o[i];
        if (acc) begin
          model_inst.add_flit(i, in_data[i]);
          acc_cnt[i]++;
        end
        if (void_i[i] || acc) begin
          if (inj_idx[i] < inj_cnt[i] && (!gaps_on || rand_bits(2) != 0)) begin
            in_data[i] <= inj_flit[i][inj_idx[i]];
            void_i[i]  <= 1'b0;
            inj_idx[i]++;
          end else begin
            void_i[i] <= 1'b1;
          end
        end
      end
      case (stop_mode)
        1: begin
          for (int o = 0; o < num_ports; o++) begin
            stop_i[o] <= (rand_bits(2) == 0);
          end
        end
        2: stop_i <= stop_force;
        default: stop_i <= '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : watch_outputs
    flit_t exp;
    bit    found;
    if (rst) begin
      hold_prev = '0;
    end else begin
      for (int o = 0; o < num_ports; o++) begin
        // Held link keeps its word
        if (hold_prev[o]) begin
          check_flit($sformatf("data_o[%0d] under stop", o), out_data[o], prev_data[o]);
          check_bit($sformatf("void_o[%0d] under stop", o), void_o[o], prev_void[o]);
        end
        if (!void_o[o] && !stop_i[o]) begin
          model_inst.take_flit(o, out_data[o], exp, found);
          if (!found) begin
            stop_on_error($sformatf("Output %0d delivered a flit that was not expected", o));
          end
          if (out_data[o][33]) begin
            check_dir($sformatf("routing field of data_o[%0d]", o), out_data[o][4:0], exp[4:0]);
          end
          check_flit($sformatf("data_o[%0d]", o), out_data[o], exp);
        end
        prev_data[o] = out_data[o];
        prev_void[o] = void_o[o];
        hold_prev[o] = stop_i[o];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : run_test
    int    n;
    int    base;
    flit_t exp;
    rst        = 1'b1;
    position   = {3'd2, 3'd2};
    void_i     = '1;
    stop_i     = '0;
    gaps_on    = 1'b0;
    stop_mode  = 0;
    stop_force = '0;
    for (int i = 0; i < num_ports; i++) begin
      in_data[i] = '0;
      inj_cnt[i] = 0;
      inj_idx[i] = 0;
      acc_cnt[i] = 0;
      seq[i]     = 0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    #1;

    // Reset values of the link bits
    for (int o = 0; o < num_ports; o++) begin
      check_bit($sformatf("void_o[%0d]", o), void_o[o], 1'b1);
      check_bit($sformatf("stop_o[%0d]", o), stop_o[o], 1'b0);
    end

    // Single flit from local to east through an idle router
    push_worm(4, {3'd4, 3'd2}, 1);
    @(posedge clk);
    @(posedge clk);
    #1;
    exp      = inj_flit[4][0];
    exp[4:0] = model_inst.next_hop(3, {3'd4, 3'd2});
    check_bit("void_o[3] one cycle after arrival", void_o[3], 1'b0);
    check_flit("data_o[3] one cycle after arrival", out_data[3], exp);
    wait_drained(100, "single flit");

    // Local queue fills and stops while east is held
    stop_force = 5'b01000;
    stop_mode  = 2;
    @(posedge clk);
    #1;
    base = acc_cnt[4];
    push_worm(4, {3'd5, 3'd1}, 6);
    n = 0;
    while (!stop_o[4] && n < 50) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!stop_o[4]) stop_on_error("stop_o of the local input never rose");
    check_bit("local queue full at four flits", (acc_cnt[4] - base) == 4, 1'b1);
    repeat (10) @(posedge clk);
    #1;
    stop_mode = 0;
    wait_drained(200, "held worm");

    // Random worms on all inputs under random stop
    for (int i = 0; i < num_ports; i++) begin
      for (int w = 0; w < 40; w++) begin
        random_worm(i);
      end
    end
    gaps_on   = 1'b1;
    stop_mode = 1;
    wait_drained(20000, "random traffic");

    $display("sim passed");
    $finish;
  end

endmodule

/* testbench/tb_router_model.sv */
/*
  Reference model of the mesh router
  Expected flits per output and input pair, in arrival order
  XY route at this tile and look-ahead next hop
  Worm lock per output to follow one worm to its tail
*/

`timescale 1ns/1ns

module tb_router_model (
  input noc_pkg::xy_t position_i
);

  import noc_pkg::*;

  localparam int slots = 512;

  flit_t exp_mem [num_ports*num_ports][slots];
  int    wr_cnt [num_ports*num_ports];
  int    rd_cnt [num_ports*num_ports];
  int    worm_out [num_ports];
  logic  locked [num_ports];
  int    lock_src [num_ports];

  initial begin
    for (int p = 0; p < num_ports*num_ports; p++) begin
      wr_cnt[p] = 0;
      rd_cnt[p] = 0;
    end
    for (int i = 0; i < num_ports; i++) begin
      worm_out[i] = 0;
      locked[i]   = 1'b0;
      lock_src[i] = 0;
    end
  end

  // Output port taken at tile here, X first then Y
  function automatic int xy_port(xy_t here, xy_t dest);
    if (dest[5:3] > here[5:3]) return 3;
    if (dest[5:3] < here[5:3]) return 2;
    if (dest[2:0] > here[2:0]) return 1;
    if (dest[2:0] < here[2:0]) return 0;
    return 4;
  endfunction

  // Direction at the tile behind an output, north is y minus 1
  function automatic dir_t next_hop(int out_port, xy_t dest);
    coord_t nx;
    coord_t ny;
    dir_t   d;
    nx = position_i[5:3];
    ny = position_i[2:0];
    d  = '0;
    case (out_port)
      0: ny = ny - 3'd1;
      1: ny = ny + 3'd1;
      2: nx = nx - 3'd1;
      3: nx = nx + 3'd1;
      default: return 5'b10000;
    endcase
    d[xy_port({nx, ny}, dest)] = 1'b1;
    return d;
  endfunction

  // Flit accepted by the router on input in_port
  task automatic add_flit(int in_port, flit_t f);
    int    p;
    flit_t e;
    xy_t   dest;
    e = f;
    if (f[33]) begin
      dest              = f[31:26];
      worm_out[in_port] = xy_port(position_i, dest);
      e[4:0]            = next_hop(worm_out[in_port], dest);
    end
    p = worm_out[in_port]*num_ports + in_port;
    exp_mem[p][wr_cnt[p] % slots] = e;
    wr_cnt[p]++;
  endtask

  // Expected flit for a delivery; the source field picks the input of a new worm
  task automatic take_flit(int out_port, flit_t got, output flit_t exp, output bit found);
    int src;
    int p;
    found = 1'b0;
    exp   = '0;
    if (locked[out_port]) begin
      src = lock_src[out_port];
    end else if (got[33]) begin
      src = int'(got[25:20]);
    end else begin
      return;
    end
    if (src >= num_ports) return;
    p = out_port*num_ports + src;
    if (rd_cnt[p] == wr_cnt[p]) return;
    exp = exp_mem[p][rd_cnt[p] % slots];
    rd_cnt[p]++;
    found = 1'b1;
    if (exp[33] && !exp[32]) begin
      locked[out_port]   = 1'b1;
      lock_src[out_port] = src;
    end
    if (exp[32]) begin
      locked[out_port] = 1'b0;
    end
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < num_ports*num_ports; p++) begin
      n = n + wr_cnt[p] - rd_cnt[p];
    end
    return n;
  endfunction

endmodule
